/* program.hex */
// One RV32I instruction word per line, byte addresses 0x00 to 0x3c
00500093
FFF08113
002081B3
00812203
FE41AE23
00208863
FE019CE3
001000EF
00C08067
123452B7
FFFFF317
00000073
FFFFFFFF
404183B3
80028403
300024F3

/* src.f */
letc_core_pkg.sv
imem.sv
core_s1_control.sv
core_s1.sv
fetch_fifo.sv
core_s2.sv
core_frontend.sv
tb_core_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f src.f \
    --top-module tb_core_frontend \
    --Mdir obj_dir \
    -o tb_core_frontend

./obj_dir/tb_core_frontend | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run_sim: failures found in sim.log"
    exit 1
fi
echo "run_sim: no failures found in sim.log"

/* tb_core_frontend.sv */
// Testbench for the core front end
// Table-driven decode checks under steady flow, random and held
// back-pressure, and a halt request

`timescale 1ns/100ps

module tb_core_frontend
    import letc_core_pkg::*;
();

    localparam int N_SEQ           = 32;  // Two passes through memory
    localparam int N_RAND          = 48;
    localparam int N_HOLD          = 8;   // Outputs checked after the long stall
    localparam int STALL_CYCLES    = 20;
    localparam int QUIET_CYCLES    = 40;
    localparam int N_TESTS         = 5;
    localparam int EXP_OUTPUTS     = N_SEQ + N_RAND + N_HOLD + FIFO_DEPTH + 1;
    localparam int WATCHDOG_CYCLES = 50 * EXP_OUTPUTS + 200 * N_TESTS;

    // One row per word of program.hex
    typedef struct packed {
        word_t      instr;
        op_class_t  op_class;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        word_t      imm;
    } prog_row_t;

    logic        clk;
    logic        rst_n;
    logic        halt_req;
    logic        dec_stall;
    logic        dec_valid;
    decoded_t    dec_out;
    logic        halted;

    prog_row_t   prog_rows [IMEM_WORDS];
    decoded_t    held;        // dec_out snapshot during the long stall
    logic [31:0] rng_state;
    int unsigned out_idx;     // Index of the next expected output
    int          err_count;
    int          check_count;
    int          tests_bad;
    int          test_errs;   // err_count at test start

    core_frontend dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt_req  (halt_req),
        .dec_stall (dec_stall),
        .dec_valid (dec_valid),
        .dec_out   (dec_out),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Fields worked out by hand from the RV32I encodings
    // Register columns hold the raw slots for every format
    task automatic load_table();
        prog_rows[0]  = '{32'h0050_0093, OP_IMM,  5'd1,  5'd0,  5'd5,  32'h0000_0005}; // addi
        prog_rows[1]  = '{32'hFFF0_8113, OP_IMM,  5'd2,  5'd1,  5'd31, 32'hFFFF_FFFF};
        prog_rows[2]  = '{32'h0020_81B3, OP,      5'd3,  5'd1,  5'd2,  32'h0000_0000}; // add
        prog_rows[3]  = '{32'h0081_2203, LOAD,    5'd4,  5'd2,  5'd8,  32'h0000_0008}; // lw
        prog_rows[4]  = '{32'hFE41_AE23, STORE,   5'd28, 5'd3,  5'd4,  32'hFFFF_FFFC}; // sw -4
        prog_rows[5]  = '{32'h0020_8863, BRANCH,  5'd16, 5'd1,  5'd2,  32'h0000_0010}; // beq +16
        prog_rows[6]  = '{32'hFE01_9CE3, BRANCH,  5'd25, 5'd3,  5'd0,  32'hFFFF_FFF8}; // bne -8
        prog_rows[7]  = '{32'h0010_00EF, JAL,     5'd1,  5'd0,  5'd1,  32'h0000_0800};
        prog_rows[8]  = '{32'h00C0_8067, JALR,    5'd0,  5'd1,  5'd12, 32'h0000_000C};
        prog_rows[9]  = '{32'h1234_52B7, LUI,     5'd5,  5'd8,  5'd3,  32'h1234_5000};
        prog_rows[10] = '{32'hFFFF_F317, AUIPC,   5'd6,  5'd31, 5'd31, 32'hFFFF_F000};
        prog_rows[11] = '{32'h0000_0073, SYSTEM,  5'd0,  5'd0,  5'd0,  32'h0000_0000}; // ecall
        prog_rows[12] = '{32'hFFFF_FFFF, ILLEGAL, 5'd31, 5'd31, 5'd31, 32'h0000_0000};
        prog_rows[13] = '{32'h4041_83B3, OP,      5'd7,  5'd3,  5'd4,  32'h0000_0000}; // sub
        prog_rows[14] = '{32'h8002_8403, LOAD,    5'd8,  5'd5,  5'd0,  32'hFFFF_F800}; // lb -2048
        prog_rows[15] = '{32'h3000_24F3, SYSTEM,  5'd9,  5'd0,  5'd0,  32'h0000_0000}; // csrrs
    endtask

    // k-th result in program order with pc counting past the wrap
    function automatic decoded_t expected_dec(input int unsigned k);
        prog_row_t row;
        decoded_t  e;
        row        = prog_rows[k % IMEM_WORDS];
        e.pc       = RESET_PC + word_t'(4 * k);
        e.op_class = row.op_class;
        e.rd       = row.rd;
        e.rs1      = row.rs1;
        e.rs2      = row.rs2;
        e.imm      = row.imm;
        return e;
    endfunction

    // Outputs settle at the edge and inputs change 2 ns later
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] t=%0t %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_decoded(input decoded_t actual, input decoded_t expected,
                                 input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] t=%0t %s: got pc=%h %s rd=%0d rs1=%0d rs2=%0d imm=%h",
                     $time, what, actual.pc, actual.op_class.name(), actual.rd,
                     actual.rs1, actual.rs2, actual.imm);
            $display("       expected pc=%h %s rd=%0d rs1=%0d rs2=%0d imm=%h",
                     expected.pc, expected.op_class.name(), expected.rd,
                     expected.rs1, expected.rs2, expected.imm);
        end
    endtask

    // Check a result if one came out on this edge
    task automatic take_output(output bit taken);
        taken = 1'b0;
        if (dec_valid) begin
            check_decoded(dec_out, expected_dec(out_idx),
                          $sformatf("output %0d instr %h", out_idx,
                                    prog_rows[out_idx % IMEM_WORDS].instr));
            out_idx++;
            taken = 1'b1;
        end
    endtask

    task automatic collect_outputs(input int n, input bit random_stall);
        int got;
        bit taken;
        got = 0;
        while (got < n) begin
            step();
            take_output(taken);
            if (taken) begin
                got++;
            end
            if (random_stall) begin
                rng_state = xorshift32(rng_state);
                dec_stall = rng_state[7]; // About half the cycles
            end
        end
    endtask

    task automatic end_test(input int id, input string name);
        int errs;
        errs = err_count - test_errs;
        if (errs == 0) begin
            $display("test %0d %s: ok", id, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", id, name, errs);
        end
        test_errs = err_count;
    endtask

    initial begin
        bit taken;
        int drained;
        rst_n       = 1'b0;
        halt_req    = 1'b0;
        dec_stall   = 1'b0;
        rng_state   = 32'hbd29_c0a5;
        out_idx     = 0;
        err_count   = 0;
        check_count = 0;
        tests_bad   = 0;
        test_errs   = 0;
        load_table();

        // Test 1 expects quiet outputs through reset and one cycle after
        repeat (16) begin
            step();
            check_bit(dec_valid, 1'b0, "dec_valid in reset");
            check_bit(halted, 1'b0, "halted in reset");
        end
        rst_n = 1'b1;
        step();
        check_bit(dec_valid, 1'b0, "dec_valid one cycle after reset");
        check_bit(halted, 1'b0, "halted one cycle after reset");
        end_test(1, "reset state");

        // Test 2 starts with fetch then push then pop on three edges
        step();
        check_bit(dec_valid, 1'b0, "dec_valid two cycles after reset");
        step();
        take_output(taken);
        check_bit(taken, 1'b1, "dec_valid three cycles after reset");
        collect_outputs(N_SEQ - int'(out_idx), 1'b0);
        end_test(2, "sequential decode");

        collect_outputs(N_RAND, 1'b1); // Test 3
        end_test(3, "random back-pressure");

        // Test 4 fills the buffer and freezes stage 1
        dec_stall = 1'b1;
        held      = dec_out;
        repeat (STALL_CYCLES) begin
            step();
            check_bit(dec_valid, 1'b0, "dec_valid under stall");
            check_decoded(dec_out, held, "dec_out under stall");
        end
        dec_stall = 1'b0;
        collect_outputs(N_HOLD, 1'b0);
        end_test(4, "full-buffer stall");

        // Test 5 pulses halt_req for one cycle and lets the buffer drain
        check_bit(halted, 1'b0, "halted before request");
        halt_req = 1'b1;
        step();
        halt_req = 1'b0;
        check_bit(halted, 1'b1, "halted after request");
        drained = 0;
        take_output(taken);
        if (taken) begin
            drained++;
        end
        repeat (FIFO_DEPTH + 3) begin
            step();
            check_bit(halted, 1'b1, "halted while draining");
            take_output(taken);
            if (taken) begin
                drained++;
            end
        end
        // Packets already buffered still decode after the halt
        check_bit(drained != 0, 1'b1, "output drained after halt");
        repeat (QUIET_CYCLES) begin
            step();
            check_bit(halted, 1'b1, "halted after drain");
            check_bit(dec_valid, 1'b0, "dec_valid after drain");
        end
        end_test(5, "halt");

        $display("tests %0d, with errors %0d, checks %0d, mismatches %0d, outputs %0d",
                 N_TESTS, tests_bad, check_count, err_count, out_idx);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_core_frontend

/* core_frontend.sv */
// Core front end
// Instruction memory, stage 1 fetch, fetch buffer and stage 2 decode

`timescale 1ns/100ps

module core_frontend
    import letc_core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     halt_req,
    input  logic     dec_stall,
    output logic     dec_valid,
    output decoded_t dec_out,
    output logic     halted
);

    word_t      imem_addr;
    word_t      imem_rdata;
    logic       push;
    fetch_pkt_t push_pkt;
    logic       fifo_full;   // Stage 2 busy seen by stage 1
    logic       fifo_empty;
    fetch_pkt_t fifo_head;
    logic       pop;

    imem imem_i (
        .clk   (clk),
        .addr  (imem_addr),
        .rdata (imem_rdata)
    );

    core_s1 core_s1_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .halt_req   (halt_req),
        .s2_busy    (fifo_full),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .push       (push),
        .push_pkt   (push_pkt),
        .halted     (halted)
    );

    fetch_fifo #(
        .payload_t (fetch_pkt_t),
        .DEPTH     (FIFO_DEPTH)
    ) fetch_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (push),
        .din   (push_pkt),
        .pop   (pop),
        .head  (fifo_head),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

    core_s2 core_s2_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (fifo_empty),
        .head      (fifo_head),
        .pop       (pop),
        .dec_stall (dec_stall),
        .dec_valid (dec_valid),
        .dec_out   (dec_out)
    );

endmodule : core_frontend

/* core_s2.sv */
// Stage 2 decode
// Pops fetch packets, classifies the opcode, pulls register fields,
// builds the immediate by format and registers the result

`timescale 1ns/100ps

module core_s2
    import letc_core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       empty,
    input  fetch_pkt_t head,
    output logic       pop,

    input  logic       dec_stall,  // Next stage not taking results
    output logic       dec_valid,
    output decoded_t   dec_out
);

    word_t      instr;
    logic [6:0] opcode;
    op_class_t  dec_class;
    word_t      dec_imm;
    decoded_t   dec_next;

    assign instr  = head.instr;
    assign opcode = instr[6:0];

    assign pop = ~empty & ~dec_stall;

    // Class and immediate by format
    always_comb begin
        dec_class = ILLEGAL;
        dec_imm   = '0;  // OP, SYSTEM, ILLEGAL
        case (opcode)
            OPC_LOAD: begin
                dec_class = LOAD;
                dec_imm   = {{20{instr[31]}}, instr[31:20]}; // I
            end
            OPC_STORE: begin
                dec_class = STORE;
                dec_imm   = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // S
            end
            OPC_BRANCH: begin
                dec_class = BRANCH;
                dec_imm   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0}; // B
            end
            OPC_JAL: begin
                dec_class = JAL;
                dec_imm   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0}; // J
            end
            OPC_JALR: begin
                dec_class = JALR;
                dec_imm   = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_OP:     dec_class = OP;
            OPC_OP_IMM: begin
                dec_class = OP_IMM;
                dec_imm   = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_LUI: begin
                dec_class = LUI;
                dec_imm   = {instr[31:12], 12'h000}; // U
            end
            OPC_AUIPC: begin
                dec_class = AUIPC;
                dec_imm   = {instr[31:12], 12'h000};
            end
            OPC_SYSTEM: dec_class = SYSTEM;
            default:    dec_class = ILLEGAL;
        endcase
    end

    // Register fields taken raw from their fixed slots
    assign dec_next = '{pc: head.pc, op_class: dec_class, rd: instr[11:7],
                        rs1: instr[19:15], rs2: instr[24:20], imm: dec_imm};

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= pop; // One result per pop
        end
    end

    // Result holds through a stall
    always_ff @(posedge clk) begin
        if (pop) begin
            dec_out <= dec_next;
        end
    end

endmodule : core_s2

/* fetch_fifo.sv */
// Fetch buffer
// Circular FIFO with read/write pointers and an occupancy count,
// payload type set by parameter

`timescale 1ns/100ps

module fetch_fifo
    import letc_core_pkg::*;
#(
    parameter type payload_t = fetch_pkt_t,
    parameter int  DEPTH     = FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     push,
    input  payload_t din,

    input  logic     pop,
    output payload_t head,  // Oldest entry, valid when not empty

    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH]; // Entry storage
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               wr_en;
    logic               rd_en;

    assign wr_en = push & ~full;  // Overflow push dropped
    assign rd_en = pop & ~empty;  // Underflow pop ignored

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

endmodule : fetch_fifo

/* core_s1.sv */
// Stage 1 fetch
// Holds the PC, addresses instruction memory so the returned word
// lines up with pc_ff, and pushes {pc, instr} into the fetch buffer

`timescale 1ns/100ps

module core_s1
    import letc_core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       halt_req,   // Exit instruction in M-mode
    input  logic       s2_busy,    // Buffer cannot take a packet

    output word_t      imem_addr,
    input  word_t      imem_rdata, // Word at pc_ff

    output logic       push,
    output fetch_pkt_t push_pkt,

    output logic       halted
);

    logic  s1_stall;    // Full, halted or halt request
    logic  fetch_valid; // imem_rdata holds a real fetch
    logic  advance;     // PC moves this cycle
    word_t pc_ff;
    word_t next_pc;

    core_s1_control core_s1_control_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .halt_req (halt_req),
        .s2_busy  (s2_busy),
        .s1_stall (s1_stall),
        .halted   (halted)
    );

    // Sequential only, no redirects
    assign next_pc = pc_ff + 32'd4;

    // First cycle out of reset is spent reading RESET_PC
    assign advance = fetch_valid & ~s1_stall;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pc_ff       <= RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b1;
            if (advance) begin
                pc_ff <= next_pc;
            end
        end
    end

    // Re-read pc_ff while held so rdata keeps matching it
    assign imem_addr = advance ? next_pc : pc_ff;

    // Packet pairs the word with its address
    assign push          = advance;
    assign push_pkt.pc    = pc_ff;
    assign push_pkt.instr = imem_rdata;

endmodule : core_s1

/* core_s1_control.sv */
// Stage 1 control
// Sticky halt flag plus the combined stage 1 stall

`timescale 1ns/100ps

module core_s1_control (
    input  logic clk,
    input  logic rst_n,
    input  logic halt_req, // Exit seen in M-mode downstream
    input  logic s2_busy,  // Fetch buffer full
    output logic s1_stall,
    output logic halted
);

    logic halted_ff;

    // Set on the first halt request, only reset clears it
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            halted_ff <= 1'b0;
        end else if (halt_req) begin
            halted_ff <= 1'b1;
        end
    end

    assign halted = halted_ff;

    // Live request stalls in the same cycle, before the flag is set
    assign s1_stall = halted_ff | halt_req | s2_busy;

endmodule : core_s1_control

/* imem.sv */
// Instruction memory
// Synchronous read-only store, one cycle from address to data,
// contents loaded from a hex image at elaboration

`timescale 1ns/100ps

module imem
    import letc_core_pkg::*;
(
    input  logic  clk,
    input  word_t addr,
    output word_t rdata
);

    word_t                 rom [IMEM_WORDS]; // Program storage
    logic [IMEM_IDX_W-1:0] word_idx;

    initial begin
        $readmemh(IMEM_INIT_FILE, rom);
    end

    // Byte address to word index, upper bits ignored so fetch wraps
    assign word_idx = addr[IMEM_IDX_W+1:2];

    always_ff @(posedge clk) begin
        rdata <= rom[word_idx]; // Registered read
    end

endmodule : imem

/* letc_core_pkg.sv */
// Shared types and constants for the core front end
// Word type, fetch packet, decode result and RV32I opcode map

package letc_core_pkg;

    // Basic machine word, data or address
    typedef logic [31:0] word_t;

    localparam word_t RESET_PC = 32'h0000_0000; // First fetch address

    // Instruction memory geometry
    localparam int IMEM_WORDS = 16;
    localparam int IMEM_IDX_W = $clog2(IMEM_WORDS); // Index from pc[5:2]
    localparam string IMEM_INIT_FILE = "program.hex";

    localparam int FIFO_DEPTH = 4; // Fetch buffer entries

    // RV32I base opcodes, bits 6:0
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
    localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

    // Stage 1 to stage 2 packet
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_pkt_t;

    // Operation class seen by later stages
    typedef enum logic [3:0] {
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        OP,
        OP_IMM,
        LUI,
        AUIPC,
        SYSTEM,
        ILLEGAL // Anything outside the base set
    } op_class_t;

    // Decode result, 83 bits
    typedef struct packed {
        word_t       pc;
        op_class_t   op_class;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        word_t       imm;      // Sign extended, zero when unused
    } decoded_t;

endpackage : letc_core_pkg
